// ==== source/feeder_pkg.sv ====
`default_nettype none

package feeder_pkg;

    // ----------------------------------------------------------------------
    // Device bus
    // ----------------------------------------------------------------------
    localparam int XLEN = 32;                   // Bus data and address width

    typedef logic [XLEN-1:0] word_t;            // One bus or operand word

    // Result record, carry on top of the low product sum
    typedef struct packed {
        logic  carry;                           // Carry out of lo(a*b) + c
        word_t value;                           // Low 32 bits of a*b + c
    } mac_result_t;

    localparam logic [7:0] DEV_REGION = 8'hC4;  // Top address byte of this block

    // ----------------------------------------------------------------------
    // Register map, word addresses
    // ----------------------------------------------------------------------
    localparam int OFS_W = 12;                  // Word offset inside a region

    // Region codes, word address bits 13..12
    localparam logic [1:0] REG_OP_A = 2'd0;
    localparam logic [1:0] REG_OP_B = 2'd1;
    localparam logic [1:0] REG_OP_C = 2'd2;
    localparam logic [1:0] REG_CTRL = 2'd3;

    // Offsets inside the control region
    localparam logic [OFS_W-1:0] CTRL_OFS         = 12'h000; // W: bit0 start, R: done/busy
    localparam logic [OFS_W-1:0] COUNT_OFS        = 12'h001; // Item count N
    localparam logic [OFS_W-1:0] RESULT_VALUE_OFS = 12'h800; // Result values
    localparam logic [OFS_W-1:0] RESULT_CARRY_OFS = 12'hC00; // Result carries, bit 0

    localparam int RST_STRETCH = 8;             // Extra reset cycles after usr_reset

endpackage

`default_nettype wire

// ==== source/operand_buffer.sv ====
`default_nettype none

module operand_buffer #(
    parameter type entry_t    = feeder_pkg::word_t,
    parameter int  DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  wr_en_i,
    input  logic [DEPTH_LOG2-1:0] wr_idx_i,
    input  entry_t                wr_data_i,
    input  entry_t                wr_mask_i,   // Bit write mask, all ones for full writes
    input  logic [DEPTH_LOG2-1:0] rd_idx_i,
    output entry_t                rd_data_o
);

    entry_t mem [2**DEPTH_LOG2];

    // Write port, masked bits keep their old value
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i] <= (mem[wr_idx_i] & ~wr_mask_i) | (wr_data_i & wr_mask_i);
        end
    end

    // Registered read, data one cycle after the index
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_idx_i];
    end

endmodule

`default_nettype wire

// ==== source/feed_fsm.sv ====
`default_nettype none

module feed_fsm (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    input  logic issue_last_i,
    input  logic retire_last_i,
    input  logic empty_i,
    input  logic res_valid_i,
    output logic issue_o,
    output logic busy_o,
    output logic done_o
);

    typedef enum logic [1:0] {
        ST_IDLE,                                // After reset, nothing run yet
        ST_RUN,                                 // One issue per cycle
        ST_DRAIN,                               // Wait for pipeline to empty
        ST_DONE                                 // Held until next start
    } state_t;

    state_t state_q, state_d;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_DONE: begin
                if (start_i) begin
                    state_d = empty_i ? ST_DONE : ST_RUN; // N = 0 goes straight to done
                end
            end
            ST_RUN: begin
                if (issue_last_i) begin
                    state_d = ST_DRAIN;         // Last item issued this cycle
                end
            end
            ST_DRAIN: begin
                if (res_valid_i && retire_last_i) begin
                    state_d = ST_DONE;          // Last result written this cycle
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Outputs straight from state
    assign issue_o = (state_q == ST_RUN);
    assign busy_o  = (state_q == ST_RUN) || (state_q == ST_DRAIN);
    assign done_o  = (state_q == ST_DONE);

endmodule

`default_nettype wire

// ==== source/feed_counter.sv ====
`default_nettype none

module feed_counter #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic                  issue_i,
    input  logic                  res_valid_i,
    input  logic [DEPTH_LOG2:0]   item_count_i,
    output logic [DEPTH_LOG2-1:0] issue_idx_o,
    output logic [DEPTH_LOG2-1:0] retire_idx_o,
    output logic                  issue_last_o,
    output logic                  retire_last_o,
    output logic                  empty_o
);

    // One bit wider than the buffer index, so N up to the COUNT width terminates
    logic [DEPTH_LOG2:0] issue_cnt, retire_cnt;
    logic [DEPTH_LOG2:0] last_idx;

    always_ff @(posedge clk) begin
        if (rst_i || start_i) begin
            issue_cnt  <= '0;                   // Fresh run starts at entry 0
            retire_cnt <= '0;
        end else begin
            if (issue_i) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (res_valid_i) begin
                retire_cnt <= retire_cnt + 1'b1;
            end
        end
    end

    assign last_idx = item_count_i - 1'b1;      // N-1

    assign issue_idx_o   = issue_cnt[DEPTH_LOG2-1:0];
    assign retire_idx_o  = retire_cnt[DEPTH_LOG2-1:0];
    assign issue_last_o  = (issue_cnt == last_idx);
    assign retire_last_o = (retire_cnt == last_idx);
    assign empty_o       = (item_count_i == '0);

endmodule

`default_nettype wire

// ==== source/mac_pipe.sv ====
`default_nettype none

module mac_pipe (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    issue_i,
    input  feeder_pkg::word_t       a_i,
    input  feeder_pkg::word_t       b_i,
    input  feeder_pkg::word_t       c_i,
    output logic                    res_valid_o,
    output feeder_pkg::mac_result_t res_o
);

    logic              s0_valid, s1_valid, s2_valid;
    feeder_pkg::word_t s1_prod, s1_c, s2_sum;
    logic              s2_carry;

    // ----------------------------------------------------------------------
    // Valid chain, issue plus four cycles
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            s0_valid    <= 1'b0;
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            s0_valid    <= issue_i;             // Matches the buffer read
            s1_valid    <= s0_valid;
            s2_valid    <= s1_valid;
            res_valid_o <= s2_valid;
        end
    end

    // ----------------------------------------------------------------------
    // Data stages
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (s0_valid) begin
            s1_prod <= a_i * b_i;               // Low 32 bits only
            s1_c    <= c_i;
        end
        if (s1_valid) begin
            {s2_carry, s2_sum} <= {1'b0, s1_prod} + {1'b0, s1_c};
        end
        if (s2_valid) begin
            res_o.value <= s2_sum;
            res_o.carry <= s2_carry;
        end
    end

endmodule

`default_nettype wire

// ==== source/dev_bus_port.sv ====
`default_nettype none

module dev_bus_port #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                        clk,
    input  logic                        usr_reset,
    input  logic                        dev_strobe_i,
    input  logic [feeder_pkg::XLEN-1:0] dev_addr_i,
    input  logic                        dev_we_i,
    input  logic [3:0]                  dev_be_i,
    input  feeder_pkg::word_t           dev_din_i,
    input  logic                        busy_i,
    input  logic                        done_i,
    input  feeder_pkg::mac_result_t     res_rd_data_i,
    output logic                        dev_ready_o,
    output feeder_pkg::word_t           dev_dout_o,
    output logic                        rst_o,
    output logic [2:0]                  op_wr_en_o,
    output logic [DEPTH_LOG2-1:0]       op_wr_idx_o,
    output feeder_pkg::word_t           op_wr_data_o,
    output feeder_pkg::word_t           op_wr_mask_o,
    output logic                        start_o,
    output logic [DEPTH_LOG2:0]         item_count_o,
    output logic [DEPTH_LOG2-1:0]       res_rd_idx_o
);

    localparam int OFS_W = feeder_pkg::OFS_W;
    localparam int RGN_LSB = OFS_W + 2;         // Region bits above the word offset

    typedef enum logic [1:0] {RD_ZERO, RD_REG, RD_VALUE, RD_CARRY} rd_kind_t;

    logic [feeder_pkg::RST_STRETCH-1:0] rst_sr;
    logic                acc, acc_wr, ctrl_hit, count_hit;
    logic [1:0]          region;
    logic [OFS_W-1:0]    offset;
    feeder_pkg::word_t   be_mask, count_merge, rd_reg_d, rd_reg_q;
    rd_kind_t            rd_kind_d, rd_kind_q;

    // ----------------------------------------------------------------------
    // Reset stretcher
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (usr_reset) begin
            rst_sr <= '1;
        end else begin
            rst_sr <= {rst_sr[feeder_pkg::RST_STRETCH-2:0], 1'b0}; // Shift zeros in
        end
    end
    assign rst_o = rst_sr[feeder_pkg::RST_STRETCH-1];

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------
    assign acc    = dev_strobe_i && (dev_addr_i[feeder_pkg::XLEN-1 -: 8] == feeder_pkg::DEV_REGION);
    assign acc_wr = acc && dev_we_i;
    assign region = dev_addr_i[RGN_LSB +: 2];
    assign offset = dev_addr_i[2 +: OFS_W];     // Word offset in region

    assign ctrl_hit  = (region == feeder_pkg::REG_CTRL) && (offset == feeder_pkg::CTRL_OFS);
    assign count_hit = (region == feeder_pkg::REG_CTRL) && (offset == feeder_pkg::COUNT_OFS);

    assign res_rd_idx_o = offset[DEPTH_LOG2-1:0]; // Buffer read starts at the strobe

    // Byte enables spread to a bit mask
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            be_mask[8*i +: 8] = {8{dev_be_i[i]}};
        end
    end

    // Old COUNT with the enabled bytes replaced
    assign count_merge = (feeder_pkg::word_t'(item_count_o) & ~be_mask) | (dev_din_i & be_mask);

    // Read source, picked at the strobe
    always_comb begin
        rd_kind_d = RD_ZERO;                    // Operand regions read as zero
        rd_reg_d  = '0;
        if (region == feeder_pkg::REG_CTRL) begin
            if (offset == feeder_pkg::CTRL_OFS) begin
                rd_kind_d     = RD_REG;
                rd_reg_d[1:0] = {done_i, busy_i};
            end else if (offset == feeder_pkg::COUNT_OFS) begin
                rd_kind_d              = RD_REG;
                rd_reg_d[DEPTH_LOG2:0] = item_count_o;
            end else if (offset[OFS_W-1 -: 2] == feeder_pkg::RESULT_VALUE_OFS[OFS_W-1 -: 2]) begin
                rd_kind_d = RD_VALUE;
            end else if (offset[OFS_W-1 -: 2] == feeder_pkg::RESULT_CARRY_OFS[OFS_W-1 -: 2]) begin
                rd_kind_d = RD_CARRY;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Control registers and ready pulse
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_o) begin
            dev_ready_o  <= 1'b0;
            start_o      <= 1'b0;
            op_wr_en_o   <= '0;
            item_count_o <= '0;
        end else begin
            dev_ready_o   <= acc;               // One cycle after the strobe
            start_o       <= acc_wr && ctrl_hit && dev_din_i[0] && !busy_i; // Ignored while busy
            op_wr_en_o[0] <= acc_wr && (region == feeder_pkg::REG_OP_A);
            op_wr_en_o[1] <= acc_wr && (region == feeder_pkg::REG_OP_B);
            op_wr_en_o[2] <= acc_wr && (region == feeder_pkg::REG_OP_C);
            if (acc_wr && count_hit) begin
                item_count_o <= count_merge[DEPTH_LOG2:0];
            end
        end
    end

    // Write payload and read select, taken at the strobe
    always_ff @(posedge clk) begin
        if (acc) begin
            op_wr_idx_o  <= offset[DEPTH_LOG2-1:0];
            op_wr_data_o <= dev_din_i;
            op_wr_mask_o <= be_mask;
            rd_kind_q    <= dev_we_i ? RD_ZERO : rd_kind_d;
            rd_reg_q     <= rd_reg_d;
        end
    end

    // Read data, valid with ready
    always_comb begin
        case (rd_kind_q)
            RD_REG:   dev_dout_o = rd_reg_q;
            RD_VALUE: dev_dout_o = res_rd_data_i.value;
            RD_CARRY: dev_dout_o = feeder_pkg::word_t'(res_rd_data_i.carry); // Carry in bit 0
            default:  dev_dout_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/feeder_top.sv ====
`default_nettype none

module feeder_top #(
    parameter int DEPTH_LOG2 = 8                // 256 entries per buffer
) (
    input  logic                        clk,
    input  logic                        usr_reset,
    input  logic                        dev_strobe_i,
    input  logic [feeder_pkg::XLEN-1:0] dev_addr_i,
    input  logic                        dev_we_i,
    input  logic [3:0]                  dev_be_i,
    input  feeder_pkg::word_t           dev_din_i,
    output logic                        dev_ready_o,
    output feeder_pkg::word_t           dev_dout_o
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------
    logic                    rst;               // Stretched reset
    logic [2:0]              op_wr_en;          // One per operand buffer, A=0
    logic [DEPTH_LOG2-1:0]   op_wr_idx;
    feeder_pkg::word_t       op_wr_data;
    feeder_pkg::word_t       op_wr_mask;        // Byte enables as bit mask
    logic                    start;
    logic [DEPTH_LOG2:0]     item_count;
    logic [DEPTH_LOG2-1:0]   res_rd_idx;
    feeder_pkg::mac_result_t res_rd_data;

    logic                    busy, done, issue;
    logic                    issue_last, retire_last, empty;
    logic [DEPTH_LOG2-1:0]   issue_idx, retire_idx;

    feeder_pkg::word_t       op_a, op_b, op_c;  // Operands, one cycle after issue
    logic                    res_valid;
    feeder_pkg::mac_result_t res;

    dev_bus_port #(.DEPTH_LOG2(DEPTH_LOG2)) i_dev_bus_port (
        .clk            (clk),
        .usr_reset      (usr_reset),
        .dev_strobe_i   (dev_strobe_i),
        .dev_addr_i     (dev_addr_i),
        .dev_we_i       (dev_we_i),
        .dev_be_i       (dev_be_i),
        .dev_din_i      (dev_din_i),
        .busy_i         (busy),
        .done_i         (done),
        .res_rd_data_i  (res_rd_data),
        .dev_ready_o    (dev_ready_o),
        .dev_dout_o     (dev_dout_o),
        .rst_o          (rst),
        .op_wr_en_o     (op_wr_en),
        .op_wr_idx_o    (op_wr_idx),
        .op_wr_data_o   (op_wr_data),
        .op_wr_mask_o   (op_wr_mask),
        .start_o        (start),
        .item_count_o   (item_count),
        .res_rd_idx_o   (res_rd_idx)
    );

    // Operand buffers, all read at the issue index
    operand_buffer #(.entry_t(feeder_pkg::word_t), .DEPTH_LOG2(DEPTH_LOG2)) i_buf_a (
        .clk(clk), .wr_en_i(op_wr_en[0]), .wr_idx_i(op_wr_idx), .wr_data_i(op_wr_data),
        .wr_mask_i(op_wr_mask), .rd_idx_i(issue_idx), .rd_data_o(op_a)
    );
    operand_buffer #(.entry_t(feeder_pkg::word_t), .DEPTH_LOG2(DEPTH_LOG2)) i_buf_b (
        .clk(clk), .wr_en_i(op_wr_en[1]), .wr_idx_i(op_wr_idx), .wr_data_i(op_wr_data),
        .wr_mask_i(op_wr_mask), .rd_idx_i(issue_idx), .rd_data_o(op_b)
    );
    operand_buffer #(.entry_t(feeder_pkg::word_t), .DEPTH_LOG2(DEPTH_LOG2)) i_buf_c (
        .clk(clk), .wr_en_i(op_wr_en[2]), .wr_idx_i(op_wr_idx), .wr_data_i(op_wr_data),
        .wr_mask_i(op_wr_mask), .rd_idx_i(issue_idx), .rd_data_o(op_c)
    );

    // Result buffer, whole records written at the retire index
    operand_buffer #(.entry_t(feeder_pkg::mac_result_t), .DEPTH_LOG2(DEPTH_LOG2)) i_buf_res (
        .clk(clk), .wr_en_i(res_valid), .wr_idx_i(retire_idx), .wr_data_i(res),
        .wr_mask_i('1), .rd_idx_i(res_rd_idx), .rd_data_o(res_rd_data)
    );

    feed_fsm i_feed_fsm (
        .clk(clk), .rst_i(rst), .start_i(start),
        .issue_last_i(issue_last), .retire_last_i(retire_last), .empty_i(empty),
        .res_valid_i(res_valid), .issue_o(issue), .busy_o(busy), .done_o(done)
    );

    feed_counter #(.DEPTH_LOG2(DEPTH_LOG2)) i_feed_counter (
        .clk(clk), .rst_i(rst), .start_i(start), .issue_i(issue),
        .res_valid_i(res_valid), .item_count_i(item_count),
        .issue_idx_o(issue_idx), .retire_idx_o(retire_idx),
        .issue_last_o(issue_last), .retire_last_o(retire_last), .empty_o(empty)
    );

    mac_pipe i_mac_pipe (
        .clk(clk), .rst_i(rst), .issue_i(issue),
        .a_i(op_a), .b_i(op_b), .c_i(op_c),
        .res_valid_o(res_valid), .res_o(res)
    );

endmodule

`default_nettype wire

// ==== testbench/feeder_assert.sv ====
`default_nettype none

module feeder_assert (
    input logic                        clk,
    input logic                        usr_reset,
    input logic                        dev_strobe_i,
    input logic [feeder_pkg::XLEN-1:0] dev_addr_i,
    input logic                        dev_ready_o,
    input logic                        busy_i,
    input logic                        done_i,
    input logic                        rst_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic region_hit;                           // Strobe aimed at this block

    assign region_hit = dev_strobe_i &&
                        (dev_addr_i[feeder_pkg::XLEN-1 -: 8] == feeder_pkg::DEV_REGION);

    // ----------------------------------------------------------------------
    // Bus timing
    // ----------------------------------------------------------------------
    ready_after_strobe: assert property (@(posedge clk) disable iff (usr_reset || rst_o)
        region_hit |=> dev_ready_o)
        else $error("No ready one cycle after a strobe in the device region");

    ready_needs_strobe: assert property (@(posedge clk) disable iff (usr_reset || rst_o)
        dev_ready_o |-> $past(region_hit))
        else $error("Ready without a strobe in the device region one cycle before");

    ready_is_pulse: assert property (@(posedge clk) disable iff (usr_reset || rst_o)
        dev_ready_o |=> !dev_ready_o)
        else $error("Ready held high for more than one cycle");

    // ----------------------------------------------------------------------
    // Status
    // ----------------------------------------------------------------------
    busy_done_exclusive: assert property (@(posedge clk) disable iff (usr_reset || rst_o)
        !(busy_i && done_i))
        else $error("Busy and done high together");

    idle_in_reset: assert property (@(posedge clk) disable iff (usr_reset)
        rst_o |-> !busy_i)                      // Stretched part of the reset
        else $error("Busy high while the internal reset is active");

endmodule

bind dev_bus_port feeder_assert i_feeder_assert (
    .clk(clk), .usr_reset(usr_reset), .dev_strobe_i(dev_strobe_i), .dev_addr_i(dev_addr_i),
    .dev_ready_o(dev_ready_o), .busy_i(busy_i), .done_i(done_i), .rst_o(rst_o)
);

`default_nettype wire

// ==== testbench/tb_feeder_top.sv ====
`default_nettype none

module tb_feeder_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH_LOG2   = 8;
    localparam int MAX_N        = 2**DEPTH_LOG2;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;            // Inputs change after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int BUS_TIMEOUT  = 4;            // Cycles allowed for a ready
    localparam int MAX_POLLS    = MAX_N;        // Run is N+5 cycles, a poll is two
    localparam int RESTART_N    = 4;

    // Bus accesses of all tests, two cycles each, plus four polled runs
    localparam int TEST_ACCESSES = 60 + (5*MAX_N + 10) + (2*MAX_N + 10) + (3*RESTART_N + 2*MAX_N);
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + feeder_pkg::RST_STRETCH
                                   + 2*TEST_ACCESSES + 8*MAX_POLLS); // Twice for margin

    logic                        clk, usr_reset, dev_strobe_i, dev_we_i, dev_ready_o;
    logic [feeder_pkg::XLEN-1:0] dev_addr_i;
    logic [3:0]                  dev_be_i;
    feeder_pkg::word_t           dev_din_i, dev_dout_o;

    // Reference model state
    feeder_pkg::word_t model_a [MAX_N], model_b [MAX_N], model_c [MAX_N];
    feeder_pkg::word_t exp_value [MAX_N];
    logic              exp_carry [MAX_N];
    feeder_pkg::word_t rng_state, rd_data, partial;
    int                burst_n, filled;         // filled: result entries with known values

    feeder_top #(.DEPTH_LOG2(DEPTH_LOG2)) i_feeder_top (
        .clk(clk), .usr_reset(usr_reset), .dev_strobe_i(dev_strobe_i), .dev_addr_i(dev_addr_i),
        .dev_we_i(dev_we_i), .dev_be_i(dev_be_i), .dev_din_i(dev_din_i),
        .dev_ready_o(dev_ready_o), .dev_dout_o(dev_dout_o)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic feeder_pkg::word_t xorshift32(input feeder_pkg::word_t x);
        feeder_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic feeder_pkg::word_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Byte address from region code and word offset
    function automatic feeder_pkg::word_t dev_addr(input logic [1:0] region, input logic [11:0] ofs);
        return {feeder_pkg::DEV_REGION, 8'h00, region, ofs, 2'b00};
    endfunction

    function automatic feeder_pkg::word_t be_to_mask(input logic [3:0] be);
        feeder_pkg::word_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    // {carry, value} of a*b + c in 32-bit wrapping arithmetic
    function automatic logic [32:0] mac_model(input feeder_pkg::word_t a, b, c);
        feeder_pkg::word_t value;
        value = a * b + c;                      // Wraps to the low 32 bits
        return {value < c, value};              // Sum below c only after a wrap
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input feeder_pkg::word_t expected,
                               input feeder_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    // One strobe, then wait for the ready pulse and take the data at the falling edge
    task automatic bus_access(input feeder_pkg::word_t addr, input logic we, input logic [3:0] be,
                              input feeder_pkg::word_t din, output feeder_pkg::word_t dout);
        int waited;
        dev_strobe_i = 1'b1;
        dev_addr_i   = addr;
        dev_we_i     = we;
        dev_be_i     = be;
        dev_din_i    = din;
        @(posedge clk);
        #DRIVE_DELAY;
        dev_strobe_i = 1'b0;
        dev_we_i     = 1'b0;
        waited       = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!dev_ready_o && waited < BUS_TIMEOUT);
        if (!dev_ready_o) begin
            $display("No ready within %0d cycles for address 0x%08h", BUS_TIMEOUT, addr);
            abort_run();
        end
        dout = dev_dout_o;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic bus_write(input feeder_pkg::word_t addr, input logic [3:0] be,
                             input feeder_pkg::word_t din);
        feeder_pkg::word_t unused;
        bus_access(addr, 1'b1, be, din, unused);
    endtask

    task automatic bus_read(input feeder_pkg::word_t addr, output feeder_pkg::word_t dout);
        bus_access(addr, 1'b0, 4'hF, 32'd0, dout);
    endtask

    task automatic write_item(input int idx, input feeder_pkg::word_t a, b, c);
        model_a[idx] = a;
        model_b[idx] = b;
        model_c[idx] = c;
        bus_write(dev_addr(feeder_pkg::REG_OP_A, 12'(idx)), 4'hF, a);
        bus_write(dev_addr(feeder_pkg::REG_OP_B, 12'(idx)), 4'hF, b);
        bus_write(dev_addr(feeder_pkg::REG_OP_C, 12'(idx)), 4'hF, c);
    endtask

    // COUNT, then start; the model fills in what the run will write
    task automatic start_run(input int n);
        logic [32:0] r;
        bus_write(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::COUNT_OFS), 4'hF, 32'(n));
        bus_write(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), 4'hF, 32'd1);
        for (int i = 0; i < n; i++) begin
            r            = mac_model(model_a[i], model_b[i], model_c[i]);
            exp_value[i] = r[31:0];
            exp_carry[i] = r[32];
        end
        if (n > filled) begin
            filled = n;
        end
    endtask

    task automatic poll_done(input string name);
        feeder_pkg::word_t status;
        int                polls;
        polls = 0;
        do begin
            bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), status);
            polls++;
        end while (!status[1] && polls < MAX_POLLS);
        if (!status[1]) begin
            $display("%s: done did not rise within %0d polls", name, MAX_POLLS);
            abort_run();
        end
        check_value({name, " ctrl at done"}, 32'd2, status); // Done set, busy clear
    endtask

    task automatic check_results(input string name, input int count);
        feeder_pkg::word_t v;
        for (int i = 0; i < count; i++) begin
            bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::RESULT_VALUE_OFS + 12'(i)), v);
            check_value($sformatf("%s value[%0d]", name, i), exp_value[i], v);
            bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::RESULT_CARRY_OFS + 12'(i)), v);
            check_value($sformatf("%s carry[%0d]", name, i), 32'(exp_carry[i]), v);
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    initial begin
        clk          = 1'b0;
        usr_reset    = 1'b1;
        dev_strobe_i = 1'b0;
        dev_addr_i   = '0;
        dev_we_i     = 1'b0;
        dev_be_i     = 4'h0;
        dev_din_i    = '0;
        rng_state    = 32'd3;                   // Fixed seed
        filled       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        usr_reset = 1'b0;
        repeat (feeder_pkg::RST_STRETCH + 2) @(posedge clk); // Stretched reset tail
        #DRIVE_DELAY;

        // After reset, plus an operand read and a strobe outside the region
        bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), rd_data);
        check_value("reset ctrl", 32'd0, rd_data);
        bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::COUNT_OFS), rd_data);
        check_value("reset count", 32'd0, rd_data);
        bus_read(dev_addr(feeder_pkg::REG_OP_A, 12'd0), rd_data);
        check_value("operand read", 32'd0, rd_data);
        dev_strobe_i = 1'b1;
        dev_addr_i   = 32'hC500_0000;
        @(posedge clk);
        #DRIVE_DELAY;
        dev_strobe_i = 1'b0;
        repeat (BUS_TIMEOUT) begin
            @(negedge clk);
            check_value("no ready outside region", 32'd0, 32'(dev_ready_o));
        end
        @(posedge clk);
        #DRIVE_DELAY;

        // N = 0 from idle, done must come from the start itself
        start_run(0);
        bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), rd_data);
        check_value("zero count from idle", 32'd2, rd_data);

        // Single item, c all ones so the carry is set
        write_item(0, next_rand(), next_rand(), 32'hFFFF_FFFF);
        start_run(1);
        poll_done("single");
        check_results("single", 1);

        // Random burst
        burst_n = 2 + int'(next_rand() % 32'd255);
        for (int i = 0; i < burst_n; i++) begin
            write_item(i, next_rand(), next_rand(), next_rand());
        end
        start_run(burst_n);
        bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), rd_data);
        check_value("burst busy after start", 32'd1, rd_data);
        poll_done("burst");
        check_results("burst", filled);

        // Partial write into operand A, bytes 0 and 2
        write_item(0, next_rand(), next_rand(), next_rand());
        partial = next_rand();
        bus_write(dev_addr(feeder_pkg::REG_OP_A, 12'd0), 4'b0101, partial);
        model_a[0] = (model_a[0] & ~be_to_mask(4'b0101)) | (partial & be_to_mask(4'b0101));
        start_run(1);
        poll_done("byte enable");
        check_results("byte enable", 1);

        // N = 0, old results stay
        start_run(0);
        bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), rd_data);
        check_value("zero count ctrl", 32'd2, rd_data);
        check_results("zero count readback", filled);

        // Restart over the first entries
        for (int i = 0; i < RESTART_N; i++) begin
            write_item(i, next_rand(), next_rand(), next_rand());
        end
        start_run(RESTART_N);
        bus_read(dev_addr(feeder_pkg::REG_CTRL, feeder_pkg::CTRL_OFS), rd_data);
        check_value("restart clears done", 32'd1, rd_data);
        poll_done("restart");
        check_results("restart", filled);

        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/feeder_pkg.sv
source/operand_buffer.sv
source/feed_fsm.sv
source/feed_counter.sv
source/mac_pipe.sv
source/dev_bus_port.sv
source/feeder_top.sv
testbench/feeder_assert.sv
testbench/tb_feeder_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_feeder_top -f verilog.f || exit 1
out=$(./obj_dir/Vtb_feeder_top 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1
